// ==== Makefile ====
TOP := logic_capture_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/1ns --top-module $(TOP) -f src.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

// ==== hw/bit_sampler.sv ====
`timescale 1ns/1ns

module bit_sampler import capture_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         restart,
    input  logic         sig,
    output sample_beat_t beat
);

    localparam int CNT_WIDTH = $clog2(SAMPLE_WIDTH);

    logic [SAMPLE_WIDTH-1:0] shift;
    logic [CNT_WIDTH-1:0]    cnt;
    logic                    strobe_q;
    sample_word_t            word_q;

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            cnt      <= '0;
            strobe_q <= 1'b0;
        end else begin
            cnt      <= cnt + 1'b1;  // wraps every word
            strobe_q <= (cnt == CNT_WIDTH'(SAMPLE_WIDTH - 1));
        end
    end

    always_ff @(posedge clk) begin
        shift <= {shift[SAMPLE_WIDTH-2:0], sig};  // first sample ends in msb
        if (cnt == CNT_WIDTH'(SAMPLE_WIDTH - 1)) begin
            word_q <= {shift[SAMPLE_WIDTH-2:0], sig};
        end
    end

    assign beat = '{strobe: strobe_q, word: word_q};

endmodule

// ==== hw/capture_pkg.sv ====
package capture_pkg;

    localparam int SAMPLE_WIDTH = 16;  // sig samples per word

    typedef logic [SAMPLE_WIDTH-1:0] sample_word_t;

    // completed word from the sampler
    typedef struct packed {
        logic         strobe;
        sample_word_t word;
    } sample_beat_t;

    // buffer write port, addr sized for the largest buffer
    typedef struct packed {
        logic         en;
        logic [7:0]   addr;
        sample_word_t data;
    } buf_wr_t;

    typedef enum logic [2:0] {
        CAPTURE,
        DUMP_LO,
        DUMP_HI,
        WAIT_TX,
        DONE
    } dump_state_t;

endpackage

// ==== hw/dump_controller.sv ====
`timescale 1ns/1ns

module dump_controller import capture_pkg::*, uart_pkg::*; #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         rearm,
    input  sample_beat_t beat,
    output buf_wr_t      wr,
    output logic [7:0]   rd_addr,
    input  sample_word_t rd_data,
    output tx_req_t      tx_req,
    input  logic         tx_busy,
    output logic         done
);

    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = '1;

    dump_state_t           state;
    logic [ADDR_WIDTH-1:0] addr;
    logic                  rd_valid;  // rd_data matches addr
    logic                  wr_hit;
    logic                  lo_go;
    logic                  hi_go;
    uart_byte_t            tx_byte;

    assign wr_hit = (state == CAPTURE) && beat.strobe;
    assign lo_go  = (state == DUMP_LO) && rd_valid && !tx_busy;
    assign hi_go  = (state == DUMP_HI) && !tx_busy;

    assign tx_byte = (state == DUMP_HI) ? rd_data[15:8] : rd_data[7:0];

    assign wr      = '{en: wr_hit, addr: 8'(addr), data: beat.word};
    assign rd_addr = 8'(addr);
    assign tx_req  = '{start: lo_go || hi_go, data: tx_byte};
    assign done    = (state == DONE);

    always_ff @(posedge clk) begin
        if (rst || rearm) begin
            state    <= CAPTURE;
            addr     <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= 1'b1;
            case (state)
                CAPTURE: begin
                    if (wr_hit) begin
                        addr     <= addr + 1'b1;  // wraps to 0 when full
                        rd_valid <= 1'b0;
                        if (addr == LAST_ADDR) begin
                            state <= DUMP_LO;
                        end
                    end
                end
                DUMP_LO: begin
                    if (lo_go) begin
                        state <= DUMP_HI;  // busy is high from next cycle
                    end
                end
                DUMP_HI: begin
                    if (hi_go) begin
                        // next word is fetched while the high byte goes out
                        addr     <= addr + 1'b1;
                        rd_valid <= 1'b0;
                        state    <= WAIT_TX;
                    end
                end
                WAIT_TX: begin
                    if (!tx_busy) begin
                        state <= (addr == '0) ? DONE : DUMP_LO;  // wrapped means all sent
                    end
                end
                default: begin
                    state <= DONE;  // hold until rearm
                end
            endcase
        end
    end

endmodule

// ==== hw/logic_capture_top.sv ====
`timescale 1ns/1ns

module logic_capture_top import capture_pkg::*, uart_pkg::*; #(
    parameter int ADDR_WIDTH   = 8,
    parameter int CLKS_PER_BIT = 40000
) (
    input  logic clk,
    input  logic rst,
    input  logic sig,
    input  logic rearm,
    output logic tx,
    output logic done
);

    sample_beat_t beat;
    buf_wr_t      buf_wr;
    logic [7:0]   rd_addr;
    sample_word_t rd_data;
    tx_req_t      tx_req;
    logic         tx_busy;

    bit_sampler u_sampler (
        .clk     (clk),
        .rst     (rst),
        .restart (rearm),  // new word alignment on rearm
        .sig     (sig),
        .beat    (beat)
    );

    sample_buffer #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_buffer (
        .clk     (clk),
        .wr      (buf_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // dump_state_t sequencing lives here
    dump_controller #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .rearm   (rearm),
        .beat    (beat),
        .wr      (buf_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .tx_req  (tx_req),
        .tx_busy (tx_busy),
        .done    (done)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_tx (
        .clk  (clk),
        .rst  (rst),
        .req  (tx_req),
        .tx   (tx),
        .busy (tx_busy)
    );

endmodule

// ==== hw/sample_buffer.sv ====
`timescale 1ns/1ns

module sample_buffer import capture_pkg::*; #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic         clk,
    input  buf_wr_t      wr,
    input  logic [7:0]   rd_addr,
    output sample_word_t rd_data
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    sample_word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr[ADDR_WIDTH-1:0]] <= wr.data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr[ADDR_WIDTH-1:0]];
    end

endmodule

// ==== hw/uart_pkg.sv ====
package uart_pkg;

    typedef logic [7:0] uart_byte_t;

    // one-cycle start with the byte to send
    typedef struct packed {
        logic       start;
        uart_byte_t data;
    } tx_req_t;

endpackage

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 40000
) (
    input  logic    clk,
    input  logic    rst,
    input  tx_req_t req,
    output logic    tx,
    output logic    busy
);

    localparam int CNT_WIDTH  = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int FRAME_BITS = 10;  // start, 8 data, stop

    logic [CNT_WIDTH-1:0]  bit_cnt;
    logic [3:0]            bit_idx;
    logic [FRAME_BITS-1:0] frame;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            if (req.start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
                bit_idx <= '0;
            end
        end else if (bit_cnt == CNT_WIDTH'(CLKS_PER_BIT - 1)) begin
            bit_cnt <= '0;
            if (bit_idx == 4'(FRAME_BITS - 1)) begin
                busy <= 1'b0;  // stop bit done
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && req.start) begin
            frame <= {1'b1, req.data, 1'b0};  // lsb first after start bit
        end else if (busy && bit_cnt == CNT_WIDTH'(CLKS_PER_BIT - 1)) begin
            frame <= {1'b1, frame[FRAME_BITS-1:1]};
        end
    end

    assign tx = busy ? frame[0] : 1'b1;  // idle high

endmodule

// ==== src.f ====
hw/capture_pkg.sv
hw/uart_pkg.sv
hw/bit_sampler.sv
hw/sample_buffer.sv
hw/dump_controller.sv
hw/uart_tx.sv
hw/logic_capture_top.sv
verification/logic_capture_tb.sv

// ==== verification/logic_capture_tb.sv ====
`timescale 1ns/1ns

module logic_capture_tb;

    localparam int ADDR_WIDTH   = 3;
    localparam int CLKS_PER_BIT = 4;
    localparam int WORDS        = 2 ** ADDR_WIDTH;
    localparam int NUM_ROWS     = 4;
    localparam int CLK_PERIOD   = 20;
    localparam int HOLD_CYCLES  = 10;  // idle check after done
    localparam int ROW_CYCLES   = WORDS * 16 + 2 * WORDS * 10 * CLKS_PER_BIT + 50;
    localparam int TIMEOUT_NS   = NUM_ROWS * ROW_CYCLES * CLK_PERIOD;

    // one capture run with words indexed by buffer address
    typedef struct packed {
        logic                   rand_fill;
        logic [WORDS-1:0][15:0] words;
    } stim_row_t;

    logic clk;
    logic rst;
    logic sig;
    logic rearm;
    logic tx;
    logic done;

    stim_row_t   stim_rows [NUM_ROWS];
    logic [15:0] cur_words [WORDS];
    logic [7:0]  expected_bytes [$];  // uart stream still to come
    int          rx_count   = 0;
    int          seed       = 32'h1375_3b0c;

    logic_capture_top #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) dut0 (
        .clk   (clk),
        .rst   (rst),
        .sig   (sig),
        .rearm (rearm),
        .tx    (tx),
        .done  (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    function automatic stim_row_t make_row(input logic rand_fill,
                                           input logic [WORDS*16-1:0] list);
        stim_row_t r;
        r.rand_fill = rand_fill;
        for (int i = 0; i < WORDS; i++) begin
            r.words[i] = list[(WORDS-1-i)*16 +: 16];  // leftmost word goes to address 0
        end
        return r;
    endfunction

    function automatic logic next_random_bit();
        logic [31:0] rnd;
        rnd = $random(seed);
        return rnd[0];
    endfunction

    // picks the words of a row and queues the bytes the uart must send
    task automatic load_row(input int row);
        logic [31:0] rnd;
        for (int w = 0; w < WORDS; w++) begin
            if (stim_rows[row].rand_fill) begin
                rnd = $random(seed);
                cur_words[w] = rnd[15:0];
            end else begin
                cur_words[w] = stim_rows[row].words[w];
            end
            expected_bytes.push_back(cur_words[w][7:0]);  // low byte first
            expected_bytes.push_back(cur_words[w][15:8]);
        end
    endtask

    // first bit goes out on the edge that releases rst or rearm
    task automatic feed_row();
        for (int w = 0; w < WORDS; w++) begin
            for (int b = 15; b >= 0; b--) begin
                if (w != 0 || b != 15) begin
                    @(posedge clk);
                end
                sig <= cur_words[w][b];  // msb first
                @(negedge clk);
                check_equal(32'(done), 32'd0, "done during capture");
                check_equal(32'(tx), 32'd1, "tx idle during capture");
            end
        end
    endtask

    task automatic wait_dump_done(input int row);
        while (done !== 1'b1) begin
            @(posedge clk);
            sig <= next_random_bit();  // must not reach the buffer
            @(negedge clk);
        end
        check_equal(32'(rx_count), 32'((row + 1) * 2 * WORDS), "bytes sent when done rose");
        check_equal(32'(expected_bytes.size()), 32'd0, "bytes left unsent");
    endtask

    task automatic hold_done(input int row);
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            sig <= next_random_bit();
            @(negedge clk);
            check_equal(32'(done), 32'd1, "done held after dump");
            check_equal(32'(tx), 32'd1, "tx idle after dump");
            check_equal(32'(rx_count), 32'((row + 1) * 2 * WORDS), "byte count after dump");
        end
    endtask

    task automatic pulse_rearm();
        @(posedge clk);
        rearm <= 1'b1;
        sig   <= next_random_bit();
        @(posedge clk);
        rearm <= 1'b0;
    endtask

    // 8N1 decoder sampling near the middle of each bit
    initial begin : uart_receiver
        logic [7:0] rx_byte;
        logic [7:0] exp_byte;
        forever begin
            @(negedge clk);
            if (rst === 1'b0 && tx === 1'b0) begin  // start bit seen
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                check_equal(32'(tx), 32'd0, "start bit");
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    rx_byte[i] = tx;  // lsb first
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                check_equal(32'(tx), 32'd1, "stop bit");
                if (expected_bytes.size() == 0) begin
                    report_error("a uart frame arrived after all bytes were sent");
                end else begin
                    exp_byte = expected_bytes.pop_front();
                    check_equal(32'(rx_byte), 32'(exp_byte),
                                $sformatf("uart byte %0d", rx_count));
                    rx_count++;
                end
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        report_error("timeout, the capture and dump did not finish in time");
    end

    initial begin : stimulus
        rst   = 1'b1;
        rearm = 1'b0;
        sig   = 1'b0;

        stim_rows[0] = make_row(1'b0, {16'h1234, 16'hABCD, 16'h0000, 16'hFFFF,
                                       16'h8001, 16'h55AA, 16'h00FF, 16'hC3A5});
        stim_rows[1] = make_row(1'b1, '0);
        stim_rows[2] = make_row(1'b0, {16'h0001, 16'h0002, 16'h0004, 16'h0080,
                                       16'h0100, 16'h2000, 16'h4000, 16'h8000});
        stim_rows[3] = make_row(1'b1, '0);

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int row = 0; row < NUM_ROWS; row++) begin
            if (row > 0) begin
                pulse_rearm();
            end
            load_row(row);
            feed_row();
            wait_dump_done(row);
            hold_done(row);
            $display("row %0d dumped, %0d bytes so far", row, rx_count);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule
